/* logic/vmem_pkg.sv */
// Vector memory stage shared types
`default_nettype none

package vmem_pkg;

  localparam int WORD_W         = 32;
  localparam int BYTES_PER_WORD = WORD_W / 8;
  localparam int OFF_W          = $clog2(BYTES_PER_WORD);  // Byte offset within a word
  localparam int VL_W           = 6;                       // Vector length and element index

  // Element width encoding
  typedef enum logic [1:0] {
    EEW8  = 2'd0,
    EEW16 = 2'd1,
    EEW32 = 2'd2
  } eew_t;

  // One finished element, scheduler to packer
  typedef struct packed {
    logic [VL_W-1:0]   index;
    eew_t              eew;
    logic [OFF_W-1:0]  byte_off;
    logic [WORD_W-1:0] word;      // Raw word as read from RAM
    logic              store;
    logic              exception; // Misaligned, no access made
    logic              last;
  } elem_rec_t;

endpackage

`default_nettype wire

/* logic/vmem_data_ram.sv */
// Byte-enabled data RAM
`default_nettype none

module vmem_data_ram import vmem_pkg::*; #(
  parameter  int RAM_WORDS = 64,
  localparam int AW        = $clog2(RAM_WORDS)
) (
  input  logic                      CLK,
  input  logic                      nRST,
  input  logic                      ren,
  input  logic                      wen,
  input  logic [AW-1:0]             addr,
  input  logic [WORD_W-1:0]         wdata,
  input  logic [BYTES_PER_WORD-1:0] byte_ena,
  output logic [WORD_W-1:0]         rdata,
  output logic                      dhit
);

  logic [WORD_W-1:0] mem [RAM_WORDS];
  logic              wait_cnt;
  logic              req;
  logic              done;

  // Pending access, not yet answered
  assign req  = (ren || wen) && !dhit;
  // Word address bit 2 selects the slow bank
  assign done = req && (wait_cnt == addr[2]);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < RAM_WORDS; i++) begin
        mem[i] <= '0;
      end
      rdata    <= '0;
      dhit     <= 1'b0;
      wait_cnt <= 1'b0;
    end else begin
      dhit <= done;
      if (done) begin
        wait_cnt <= 1'b0;
        rdata    <= mem[addr];
        if (wen) begin
          for (int b = 0; b < BYTES_PER_WORD; b++) begin
            if (byte_ena[b]) begin
              mem[addr][8*b +: 8] <= wdata[8*b +: 8];
            end
          end
        end
      end else if (req) begin
        wait_cnt <= wait_cnt + 1'b1;  // Extra cycle for slow bank
      end
    end
  end

  a_no_rw_overlap: assert property (@(posedge CLK) disable iff (!nRST)
    !(ren && wen));

endmodule

`default_nettype wire

/* logic/vmem_result_fifo.sv */
// Element record FIFO
`default_nettype none

module vmem_result_fifo #(
  parameter  int  FIFO_DEPTH = 4,
  parameter  type rec_t      = logic,
  localparam int  PW         = $clog2(FIFO_DEPTH)
) (
  input  logic CLK,
  input  logic nRST,
  input  logic push,
  input  rec_t din,
  input  logic pop,
  output rec_t head,
  output logic full,
  output logic empty
);

  rec_t          slots [FIFO_DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [PW:0]   count;    // One extra bit to tell full from empty
  logic          do_push;
  logic          do_pop;

  assign full    = (count == (PW+1)'(FIFO_DEPTH));
  assign empty   = (count == '0);
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;
  assign head    = slots[rd_ptr];  // Show-ahead

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (do_push) begin
      slots[wr_ptr] <= din;
    end
  end

  a_no_overflow: assert property (@(posedge CLK) disable iff (!nRST)
    push |-> !full);

  a_no_underflow: assert property (@(posedge CLK) disable iff (!nRST)
    pop |-> !empty);

endmodule

`default_nettype wire

/* logic/vmem_addr_scheduler.sv */
// Strided address scheduler
`default_nettype none

module vmem_addr_scheduler import vmem_pkg::*; #(
  parameter  int RAM_WORDS = 64,
  localparam int AW        = $clog2(RAM_WORDS)
) (
  input  logic                      CLK,
  input  logic                      nRST,
  input  logic                      cmd_req,
  input  logic [WORD_W-1:0]         cmd_base,
  input  logic [WORD_W-1:0]         cmd_stride,
  input  eew_t                      cmd_eew,
  input  logic [VL_W-1:0]           cmd_vl,
  input  logic                      cmd_store,
  input  logic [WORD_W-1:0]         cmd_data,
  input  logic                      dhit,
  input  logic [WORD_W-1:0]         rdata,
  input  logic                      full,
  output logic                      cmd_ack,
  output logic                      ren,
  output logic                      wen,
  output logic [AW-1:0]             addr,
  output logic [WORD_W-1:0]         wdata,
  output logic [BYTES_PER_WORD-1:0] byte_ena,
  output logic                      push,
  output elem_rec_t                 rec
);

  localparam int BA_W = AW + OFF_W;  // Byte address width

  typedef enum logic [1:0] {S_IDLE, S_ISSUE, S_WAIT, S_PUSH} state_t;

  state_t            state;
  logic              accept;
  logic              misalign;
  logic              last;
  logic [VL_W-1:0]   idx;
  logic [BA_W-1:0]   elem_addr;   // Running element byte address
  logic [BA_W-1:0]   stride_q;
  eew_t              eew_q;
  logic [VL_W-1:0]   vl_q;
  logic              store_q;
  logic [WORD_W-1:0] data_q;
  logic [WORD_W-1:0] word_q;
  logic              exc_q;

  assign accept = (state == S_IDLE) && cmd_req && !cmd_ack;
  assign last   = (idx == vl_q - 1'b1);
  assign addr   = elem_addr[BA_W-1:OFF_W];
  assign push   = (state == S_PUSH);

  // Alignment, lane enables and splat data per width
  always_comb begin
    case (eew_q)
      EEW8: begin
        misalign = 1'b0;
        byte_ena = 4'b0001 << elem_addr[OFF_W-1:0];
        wdata    = {4{data_q[7:0]}};
      end
      EEW16: begin
        misalign = elem_addr[0];
        byte_ena = 4'b0011 << elem_addr[OFF_W-1:0];
        wdata    = {2{data_q[15:0]}};
      end
      default: begin
        misalign = |elem_addr[OFF_W-1:0];
        byte_ena = 4'b1111;
        wdata    = data_q;
      end
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state   <= S_IDLE;
      cmd_ack <= 1'b0;
      ren     <= 1'b0;
      wen     <= 1'b0;
      idx     <= '0;
    end else begin
      if (accept) begin
        cmd_ack <= 1'b1;
      end else if (cmd_ack && !cmd_req) begin
        cmd_ack <= 1'b0;  // Four-phase return to zero
      end
      case (state)
        S_IDLE: begin
          if (accept) begin
            idx   <= '0;
            state <= S_ISSUE;
          end
        end
        S_ISSUE: begin
          if (!full) begin  // Stall here on back-pressure
            if (misalign) begin
              state <= S_PUSH;
            end else begin
              ren   <= !store_q;
              wen   <= store_q;
              state <= S_WAIT;
            end
          end
        end
        S_WAIT: begin
          if (dhit) begin
            ren   <= 1'b0;
            wen   <= 1'b0;
            state <= S_PUSH;
          end
        end
        default: begin
          idx   <= idx + 1'b1;
          state <= last ? S_IDLE : S_ISSUE;
        end
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (accept) begin
      elem_addr <= cmd_base[BA_W-1:0];
      stride_q  <= cmd_stride[BA_W-1:0];
      eew_q     <= cmd_eew;
      vl_q      <= cmd_vl;
      store_q   <= cmd_store;
      data_q    <= cmd_data;
    end else if (state == S_PUSH) begin
      elem_addr <= elem_addr + stride_q;  // Wraps at RAM size
    end
    if (state == S_ISSUE && !full) begin
      exc_q  <= misalign;
      word_q <= '0;
    end else if (state == S_WAIT && dhit) begin
      word_q <= rdata;
    end
  end

  assign rec.index     = idx;
  assign rec.eew       = eew_q;
  assign rec.byte_off  = elem_addr[OFF_W-1:0];
  assign rec.word      = word_q;
  assign rec.store     = store_q;
  assign rec.exception = exc_q;
  assign rec.last      = last;

  a_ack_after_req: assert property (@(posedge CLK) disable iff (!nRST)
    $rose(cmd_ack) |-> $past(cmd_req));

  a_no_push_full: assert property (@(posedge CLK) disable iff (!nRST)
    push |-> !full);

endmodule

`default_nettype wire

/* logic/vmem_writeback_packer.sv */
// Writeback element packer
`default_nettype none

module vmem_writeback_packer import vmem_pkg::*; (
  input  logic              CLK,
  input  logic              nRST,
  input  elem_rec_t         head,
  input  logic              empty,
  input  logic              wb_ack,
  output logic              pop,
  output logic              wb_req,
  output logic [VL_W-1:0]   wb_index,
  output logic [WORD_W-1:0] wb_data,
  output logic              wb_store,
  output logic              wb_exception,
  output logic              wb_last
);

  typedef enum logic [1:0] {P_IDLE, P_REQ, P_DROP} pstate_t;

  pstate_t           state;
  logic [WORD_W-1:0] shifted;
  logic [WORD_W-1:0] element;

  assign pop     = (state == P_IDLE) && !empty;
  assign shifted = head.word >> {head.byte_off, 3'b000};

  // Zero-extend at element width
  always_comb begin
    case (head.eew)
      EEW8:    element = WORD_W'(shifted[7:0]);
      EEW16:   element = WORD_W'(shifted[15:0]);
      default: element = shifted;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state  <= P_IDLE;
      wb_req <= 1'b0;
    end else begin
      case (state)
        P_IDLE: begin
          if (pop) begin
            wb_req <= 1'b1;
            state  <= P_REQ;
          end
        end
        P_REQ: begin
          if (wb_ack) begin
            wb_req <= 1'b0;
            state  <= P_DROP;
          end
        end
        default: begin
          if (!wb_ack) begin
            state <= P_IDLE;  // Handshake back at rest
          end
        end
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (pop) begin
      wb_index     <= head.index;
      wb_data      <= (head.store || head.exception) ? '0 : element;
      wb_store     <= head.store;
      wb_exception <= head.exception;
      wb_last      <= head.last;
    end
  end

  a_req_held: assert property (@(posedge CLK) disable iff (!nRST)
    $fell(wb_req) |-> $past(wb_ack));

endmodule

`default_nettype wire

/* logic/vmem_top.sv */
// Vector load/store memory stage
`default_nettype none

module vmem_top import vmem_pkg::*; #(
  parameter  int RAM_WORDS  = 64,
  parameter  int FIFO_DEPTH = 4,
  localparam int AW         = $clog2(RAM_WORDS)
) (
  input  logic              CLK,
  input  logic              nRST,
  input  logic              cmd_req,
  input  logic [WORD_W-1:0] cmd_base,
  input  logic [WORD_W-1:0] cmd_stride,
  input  eew_t              cmd_eew,
  input  logic [VL_W-1:0]   cmd_vl,
  input  logic              cmd_store,
  input  logic [WORD_W-1:0] cmd_data,
  output logic              cmd_ack,
  input  logic              wb_ack,
  output logic              wb_req,
  output logic [VL_W-1:0]   wb_index,
  output logic [WORD_W-1:0] wb_data,
  output logic              wb_store,
  output logic              wb_exception,
  output logic              wb_last
);

  // RAM link
  logic                      ren;
  logic                      wen;
  logic [AW-1:0]             addr;
  logic [WORD_W-1:0]         wdata;
  logic [BYTES_PER_WORD-1:0] byte_ena;
  logic [WORD_W-1:0]         rdata;
  logic                      dhit;

  // Record path
  logic      push;
  logic      full;
  logic      pop;
  logic      empty;
  elem_rec_t rec;
  elem_rec_t head;

  vmem_addr_scheduler #(
    .RAM_WORDS (RAM_WORDS)
  ) u_sched (
    .CLK        (CLK),
    .nRST       (nRST),
    .cmd_req    (cmd_req),
    .cmd_base   (cmd_base),
    .cmd_stride (cmd_stride),
    .cmd_eew    (cmd_eew),
    .cmd_vl     (cmd_vl),
    .cmd_store  (cmd_store),
    .cmd_data   (cmd_data),
    .dhit       (dhit),
    .rdata      (rdata),
    .full       (full),
    .cmd_ack    (cmd_ack),
    .ren        (ren),
    .wen        (wen),
    .addr       (addr),
    .wdata      (wdata),
    .byte_ena   (byte_ena),
    .push       (push),
    .rec        (rec)
  );

  vmem_data_ram #(
    .RAM_WORDS (RAM_WORDS)
  ) u_ram (
    .CLK      (CLK),
    .nRST     (nRST),
    .ren      (ren),
    .wen      (wen),
    .addr     (addr),
    .wdata    (wdata),
    .byte_ena (byte_ena),
    .rdata    (rdata),
    .dhit     (dhit)
  );

  vmem_result_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .rec_t      (elem_rec_t)
  ) u_fifo (
    .CLK   (CLK),
    .nRST  (nRST),
    .push  (push),
    .din   (rec),
    .pop   (pop),
    .head  (head),
    .full  (full),
    .empty (empty)
  );

  vmem_writeback_packer u_packer (
    .CLK          (CLK),
    .nRST         (nRST),
    .head         (head),
    .empty        (empty),
    .wb_ack       (wb_ack),
    .pop          (pop),
    .wb_req       (wb_req),
    .wb_index     (wb_index),
    .wb_data      (wb_data),
    .wb_store     (wb_store),
    .wb_exception (wb_exception),
    .wb_last      (wb_last)
  );

endmodule

`default_nettype wire

/* verif/vmem_tb.sv */
// Vector memory stage testbench
`default_nettype none

module vmem_tb import vmem_pkg::*;;

  localparam int RAM_WORDS  = 64;
  localparam int FIFO_DEPTH = 4;
  localparam int RAM_BYTES  = RAM_WORDS * BYTES_PER_WORD;
  localparam int MAX_CMDS   = 40;
  localparam int N_RANDOM   = 14;

  logic              CLK;
  logic              nRST;
  logic              cmd_req;
  logic [WORD_W-1:0] cmd_base;
  logic [WORD_W-1:0] cmd_stride;
  eew_t              cmd_eew;
  logic [VL_W-1:0]   cmd_vl;
  logic              cmd_store;
  logic [WORD_W-1:0] cmd_data;
  logic              cmd_ack;
  logic              wb_ack;
  logic              wb_req;
  logic [VL_W-1:0]   wb_index;
  logic [WORD_W-1:0] wb_data;
  logic              wb_store;
  logic              wb_exception;
  logic              wb_last;

  // Command table built before reset is released
  logic [31:0]     c_base   [MAX_CMDS];
  logic [31:0]     c_stride [MAX_CMDS];
  logic [31:0]     c_data   [MAX_CMDS];
  logic [1:0]      c_eew    [MAX_CMDS];
  logic [VL_W-1:0] c_vl     [MAX_CMDS];
  logic            c_store  [MAX_CMDS];
  int              n_cmds;

  // Reference memory and expected writeback stream
  logic [7:0]  mem_model [RAM_BYTES];
  logic [31:0] exp_index [$];
  logic [31:0] exp_data  [$];
  logic [31:0] exp_store [$];
  logic [31:0] exp_exc   [$];
  logic [31:0] exp_last  [$];
  string       exp_test  [$];
  int          exp_delay [$];  // wb_ack delay per item

  logic [15:0] lfsr;
  int          errors;
  int          total_items;
  int          wb_count;
  int          acks;
  logic        ack_seen;
  int          full_cycles;
  int          cycles;
  int          timeout_cycles;

  vmem_top #(
    .RAM_WORDS  (RAM_WORDS),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_dut (
    .CLK          (CLK),
    .nRST         (nRST),
    .cmd_req      (cmd_req),
    .cmd_base     (cmd_base),
    .cmd_stride   (cmd_stride),
    .cmd_eew      (cmd_eew),
    .cmd_vl       (cmd_vl),
    .cmd_store    (cmd_store),
    .cmd_data     (cmd_data),
    .cmd_ack      (cmd_ack),
    .wb_ack       (wb_ack),
    .wb_req       (wb_req),
    .wb_index     (wb_index),
    .wb_data      (wb_data),
    .wb_store     (wb_store),
    .wb_exception (wb_exception),
    .wb_last      (wb_last)
  );

  always #5 CLK = ~CLK;

  // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 stepped once per bit
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  // Record one command and predict its elements
  task automatic add_cmd(input string name, input logic [31:0] base, input logic [31:0] stride,
                         input logic [1:0] eew, input logic [VL_W-1:0] vl, input logic store,
                         input logic [31:0] data);
    int          a;
    int          size;
    logic        exc;
    logic [31:0] val;
    c_base[n_cmds]   = base;
    c_stride[n_cmds] = stride;
    c_eew[n_cmds]    = eew;
    c_vl[n_cmds]     = vl;
    c_store[n_cmds]  = store;
    c_data[n_cmds]   = data;
    n_cmds++;
    size = 1 << eew;  // Element size in bytes
    for (int i = 0; i < int'(vl); i++) begin
      a   = int'((base + 32'(i) * stride) % 32'(RAM_BYTES));
      exc = (a % size) != 0;
      val = '0;
      if (!exc && store) begin
        for (int b = 0; b < size; b++) begin
          mem_model[a + b] = data[8*b +: 8];
        end
      end else if (!exc) begin
        for (int b = 0; b < size; b++) begin
          val[8*b +: 8] = mem_model[a + b];
        end
      end
      exp_index.push_back(32'(i));
      exp_data.push_back(val);
      exp_store.push_back(32'(store));
      exp_exc.push_back(32'(exc));
      exp_last.push_back(32'(i == int'(vl) - 1));
      exp_test.push_back(name);
      exp_delay.push_back(int'(lfsr_bits(2)));
    end
    total_items += int'(vl);
  endtask

  task automatic build_tests();
    logic [31:0]     base;
    logic [31:0]     stride;
    logic [1:0]      eew;
    logic [VL_W-1:0] vl;
    logic            store;
    // Word splats, then read back across both latency classes
    add_cmd("store32_unit", 32'd0, 32'd4, 2'd2, 6'd16, 1'b1, lfsr_bits(32));
    add_cmd("load32_unit", 32'd0, 32'd4, 2'd2, 6'd16, 1'b0, 32'd0);
    // Narrow stores over a filled region, then reads at every offset
    add_cmd("store32_fill", 32'd64, 32'd4, 2'd2, 6'd8, 1'b1, lfsr_bits(32));
    add_cmd("store8_sparse", 32'd65, 32'd3, 2'd0, 6'd8, 1'b1, lfsr_bits(32));
    add_cmd("store16_pair", 32'd80, 32'd6, 2'd1, 6'd4, 1'b1, lfsr_bits(32));
    add_cmd("load8_bytes", 32'd64, 32'd1, 2'd0, 6'd32, 1'b0, 32'd0);
    add_cmd("load16_halves", 32'd64, 32'd2, 2'd1, 6'd16, 1'b0, 32'd0);
    add_cmd("load32_check", 32'd64, 32'd4, 2'd2, 6'd8, 1'b0, 32'd0);
    // Misaligned elements
    add_cmd("store32_misaligned", 32'd130, 32'd4, 2'd2, 6'd4, 1'b1, lfsr_bits(32));
    add_cmd("store16_mixed", 32'd128, 32'd1, 2'd1, 6'd8, 1'b1, lfsr_bits(32));
    add_cmd("load16_misaligned", 32'd129, 32'd2, 2'd1, 6'd4, 1'b0, 32'd0);
    add_cmd("load32_after_exc", 32'd128, 32'd4, 2'd2, 6'd4, 1'b0, 32'd0);
    for (int k = 0; k < N_RANDOM; k++) begin
      eew = 2'(lfsr_bits(2));
      if (eew == 2'd3) begin
        eew = 2'd2;
      end
      base   = lfsr_bits(10);  // Some bases wrap past the RAM size
      stride = lfsr_bits(5);
      if (lfsr_bits(1) != 32'd0) begin  // Half of them aligned
        base   = base & ~((32'd1 << eew) - 32'd1);
        stride = stride << eew;
      end
      vl    = 6'(lfsr_bits(5) + 32'd1);
      store = lfsr_bits(1) != 32'd0;
      add_cmd($sformatf("random_%0d", k), base, stride, eew, vl, store, lfsr_bits(32));
    end
  endtask

  // Four-phase command handshake
  task automatic send_cmd(input int k);
    @(posedge CLK);
    cmd_base   <= c_base[k];
    cmd_stride <= c_stride[k];
    cmd_eew    <= eew_t'(c_eew[k]);
    cmd_vl     <= c_vl[k];
    cmd_store  <= c_store[k];
    cmd_data   <= c_data[k];
    cmd_req    <= 1'b1;
    do @(posedge CLK); while (!cmd_ack);
    cmd_req <= 1'b0;
    do @(posedge CLK); while (cmd_ack);
  endtask

  task automatic compare_field(input string test, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
    assert (actual === expected) else begin
      errors++;
      $display("FAIL %s %s: expected 0x%0h, actual 0x%0h", test, field, expected, actual);
    end
  endtask

  // Check one item, then acknowledge it after its random delay
  task automatic take_writeback();
    int    delay;
    string name;
    delay = 0;
    assert (exp_index.size() != 0) else begin
      errors++;
      $display("ERROR: writeback item %0d arrived with no item left to expect", wb_count);
    end
    if (exp_index.size() != 0) begin
      name  = exp_test.pop_front();
      delay = exp_delay.pop_front();
      compare_field(name, "wb_index", exp_index.pop_front(), 32'(wb_index));
      compare_field(name, "wb_data", exp_data.pop_front(), wb_data);
      compare_field(name, "wb_store", exp_store.pop_front(), 32'(wb_store));
      compare_field(name, "wb_exception", exp_exc.pop_front(), 32'(wb_exception));
      compare_field(name, "wb_last", exp_last.pop_front(), 32'(wb_last));
    end
    wb_count++;
    repeat (delay) @(posedge CLK);
    wb_ack <= 1'b1;
    do @(posedge CLK); while (wb_req);
    wb_ack <= 1'b0;
  endtask

  initial begin
    wait (nRST === 1'b1);
    forever begin
      @(posedge CLK);
      if (wb_req) begin
        take_writeback();
      end
    end
  end

  // Count each rising cmd_ack
  always @(posedge CLK) begin
    if (cmd_ack && !ack_seen) begin
      acks++;
    end
    ack_seen <= cmd_ack;
  end

  // Back-pressure reaching the scheduler
  always @(posedge CLK) begin
    if (u_dut.full === 1'b1) begin
      full_cycles++;
    end
  end

  always @(posedge CLK) begin
    cycles++;
    if (cycles > timeout_cycles) begin
      $display("Timeout after %0d cycles with %0d of %0d writeback items seen",
               cycles, wb_count, total_items);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  initial begin
    CLK        = 1'b0;
    nRST       = 1'b0;
    cmd_req    = 1'b0;
    cmd_base   = '0;
    cmd_stride = '0;
    cmd_eew    = EEW8;
    cmd_vl     = '0;
    cmd_store  = 1'b0;
    cmd_data   = '0;
    wb_ack     = 1'b0;
    ack_seen   = 1'b0;
    lfsr       = 16'd56065;
    errors     = 0;
    n_cmds     = 0;
    total_items = 0;
    wb_count   = 0;
    acks       = 0;
    full_cycles = 0;
    cycles     = 0;
    for (int i = 0; i < RAM_BYTES; i++) begin
      mem_model[i] = 8'h00;  // RAM clears at reset
    end
    build_tests();
    timeout_cycles = 40 * total_items;
    repeat (2) @(posedge CLK);
    nRST <= 1'b1;
    for (int k = 0; k < n_cmds; k++) begin
      send_cmd(k);
    end
    while (wb_count < total_items) @(posedge CLK);
    repeat (20) @(posedge CLK);  // Catch any extra item
    assert (acks == n_cmds) else begin
      errors++;
      $display("ERROR: saw %0d command acks for %0d commands", acks, n_cmds);
    end
    assert (wb_count == total_items) else begin
      errors++;
      $display("ERROR: saw %0d writeback items, the commands asked for %0d",
               wb_count, total_items);
    end
    assert (full_cycles > 0) else begin
      errors++;
      $display("ERROR: the result FIFO never became full under the slow writeback");
    end
    $display("Errors: %0d, writeback items: %0d of %0d, command acks: %0d of %0d",
             errors, wb_count, total_items, acks, n_cmds);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
logic/vmem_pkg.sv
logic/vmem_data_ram.sv
logic/vmem_result_fifo.sv
logic/vmem_addr_scheduler.sv
logic/vmem_writeback_packer.sv
logic/vmem_top.sv
verif/vmem_tb.sv

/* Makefile */
# Verilator simulation of the vector memory stage

VERILATOR ?= verilator
TOP       ?= vmem_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
